// File: common/sort_queue_pkg.sv
`default_nettype none

package sort_queue_pkg;

    //////////////////////////////////////////////////
    // Sizes and constants
    //////////////////////////////////////////////////

    // Number of RAM slots built into the queue
    localparam int QUEUE_DEPTH = 16;

    // Address bits actually decoded by the RAM
    localparam int SLOT_ADDR_BITS = $clog2(QUEUE_DEPTH);

    // Stored or carried value
    typedef logic [31:0] queue_word_t;

    // RAM address or entry count
    typedef logic [7:0] slot_idx_t;

    // Empty slot marker that sorts below every real value
    localparam queue_word_t EMPTY_WORD = 32'hFFFFFFFF;

    //////////////////////////////////////////////////
    // Controller states
    //////////////////////////////////////////////////

    typedef enum logic [2:0] {
        ST_FILL,        // Marker fill after reset
        ST_IDLE,        // Waiting for insert with the read port open
        ST_READ,        // Slot address presented to RAM
        ST_CMP_WRITE,   // Router result written back
        ST_FINISH       // Walk over and count bumped
    } ctrl_state_t;

    //////////////////////////////////////////////////
    // Result bundles
    //////////////////////////////////////////////////

    // Router decision for one slot
    typedef struct packed {
        logic        swap;
        queue_word_t write_word;
        queue_word_t carry_word;
    } route_result_t;

    // Counter view for the controller
    typedef struct packed {
        slot_idx_t count;
        slot_idx_t count_next;
        logic      full;
    } count_status_t;

endpackage

`default_nettype wire

// File: src/value_router.sv
`timescale 1ns/1ps
`default_nettype none

module value_router (
    // Value travelling down the queue
    input  sort_queue_pkg::queue_word_t   carried,
    // Word read back from the current slot
    input  sort_queue_pkg::queue_word_t   stored,
    output sort_queue_pkg::route_result_t route
);

    //////////////////////////////////////////////////
    // Compare
    //////////////////////////////////////////////////

    logic stored_empty;
    logic carried_larger;

    // Marker in the slot means the slot is free
    assign stored_empty = (stored == sort_queue_pkg::EMPTY_WORD);

    // Strict compare, equal values stay put
    assign carried_larger = (carried > stored);

    //////////////////////////////////////////////////
    // Route
    //////////////////////////////////////////////////

    always_comb begin
        // Empty slot always takes the carried value
        route.swap = carried_larger || stored_empty;

        if (route.swap) begin
            // Larger value lands in this slot
            route.write_word = carried;
            // Displaced word moves on down
            route.carry_word = stored;
        end else begin
            // Slot keeps its word
            route.write_word = stored;
            // Carried value keeps walking
            route.carry_word = carried;
        end
    end

    // Non-increasing order holds since the larger
    // of the pair always stays at the lower slot

endmodule

`default_nettype wire

// File: src/slot_counter.sv
`timescale 1ns/1ps
`default_nettype none

module slot_counter (
    input  logic                          clk,
    input  logic                          reset,
    // Restart from zero
    input  logic                          clear,
    // One more entry held
    input  logic                          increment,
    // Run-time limit on entries
    input  sort_queue_pkg::slot_idx_t     capacity,
    output sort_queue_pkg::count_status_t status
);

    sort_queue_pkg::slot_idx_t count_q;
    logic at_capacity;
    logic at_depth;

    //////////////////////////////////////////////////
    // Count register
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            count_q <= '0;
        end else if (increment) begin
            count_q <= status.count_next;
        end
    end

    //////////////////////////////////////////////////
    // Status
    //////////////////////////////////////////////////

    // Limit set by the outside
    assign at_capacity = (count_q == capacity);

    // Built depth caps any larger capacity
    assign at_depth = (count_q == sort_queue_pkg::slot_idx_t'(sort_queue_pkg::QUEUE_DEPTH));

    assign status.count      = count_q;
    assign status.count_next = count_q + 8'd1;
    assign status.full       = at_capacity || at_depth;

endmodule

`default_nettype wire

// File: src/queue_bram.sv
`timescale 1ns/1ps
`default_nettype none

module queue_bram (
    input  logic                        clk,
    input  sort_queue_pkg::slot_idx_t   addr,
    input  logic                        write_en,
    input  sort_queue_pkg::queue_word_t write_data,
    output sort_queue_pkg::queue_word_t read_data
);

    //////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////

    // Contents are unknown until the marker fill runs
    sort_queue_pkg::queue_word_t mem [sort_queue_pkg::QUEUE_DEPTH];

    logic [sort_queue_pkg::SLOT_ADDR_BITS-1:0] word_sel;

    // Only the low address bits select a word
    assign word_sel = addr[sort_queue_pkg::SLOT_ADDR_BITS-1:0];

    //////////////////////////////////////////////////
    // Single port access
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (write_en) begin
            mem[word_sel] <= write_data;
            // Write first, new word shows on the output
            read_data     <= write_data;
        end else begin
            // Registered read, one cycle latency
            read_data     <= mem[word_sel];
        end
    end

endmodule

`default_nettype wire

// File: insert_ctrl/insert_controller.sv
`timescale 1ns/1ps
`default_nettype none

module insert_controller (
    input  logic                          clk,
    input  logic                          reset,
    // Insert request, one cycle
    input  logic                          insert,
    input  sort_queue_pkg::queue_word_t   insert_value,
    // Router decision for the slot under the walk
    input  sort_queue_pkg::route_result_t route,
    // Counter state
    input  sort_queue_pkg::count_status_t status,
    // RAM port
    output sort_queue_pkg::slot_idx_t     ram_addr,
    output logic                          ram_write_en,
    output sort_queue_pkg::queue_word_t   ram_write_data,
    // Value handed to the router
    output sort_queue_pkg::queue_word_t   carried,
    output logic                          count_increment,
    output logic                          count_clear,
    output logic                          ready,
    output logic                          done,
    output logic                          rejected
);

    sort_queue_pkg::ctrl_state_t state;
    sort_queue_pkg::slot_idx_t   slot;
    sort_queue_pkg::queue_word_t carry_q;
    logic last_fill;
    logic last_slot;
    logic accept;

    // Final slot of the marker fill
    assign last_fill = (slot == sort_queue_pkg::slot_idx_t'(sort_queue_pkg::QUEUE_DEPTH - 1));

    // Walk ends on the first free slot
    assign last_slot = (slot == status.count);

    // Strobe only counts while idle
    assign accept = (state == sort_queue_pkg::ST_IDLE) && insert;

    //////////////////////////////////////////////////
    // State and slot index
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= sort_queue_pkg::ST_FILL;
            slot     <= '0;
            done     <= 1'b0;
            rejected <= 1'b0;
        end else begin
            // Pulses last one cycle
            done     <= 1'b0;
            rejected <= 1'b0;

            case (state)
                sort_queue_pkg::ST_FILL: begin
                    if (last_fill) begin
                        state <= sort_queue_pkg::ST_IDLE;
                        slot  <= '0;
                    end else begin
                        slot  <= slot + 8'd1;
                    end
                end

                sort_queue_pkg::ST_IDLE: begin
                    if (accept) begin
                        if (status.full) begin
                            // Nothing written, just refuse
                            rejected <= 1'b1;
                        end else begin
                            state <= sort_queue_pkg::ST_READ;
                            slot  <= '0;
                        end
                    end
                end

                // RAM word arrives next cycle
                sort_queue_pkg::ST_READ: begin
                    state <= sort_queue_pkg::ST_CMP_WRITE;
                end

                sort_queue_pkg::ST_CMP_WRITE: begin
                    if (last_slot) begin
                        state <= sort_queue_pkg::ST_FINISH;
                    end else begin
                        state <= sort_queue_pkg::ST_READ;
                        slot  <= slot + 8'd1;
                    end
                end

                // Count bumps on this edge, so done sees the new count
                sort_queue_pkg::ST_FINISH: begin
                    done  <= 1'b1;
                    state <= sort_queue_pkg::ST_IDLE;
                end

                default: begin
                    state <= sort_queue_pkg::ST_FILL;
                    slot  <= '0;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Carry register
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (accept) begin
            carry_q <= insert_value;
        end else if (state == sort_queue_pkg::ST_CMP_WRITE && route.swap) begin
            // Displaced word continues the walk
            carry_q <= route.carry_word;
        end
    end

    assign carried = carry_q;

    //////////////////////////////////////////////////
    // RAM and counter controls
    //////////////////////////////////////////////////

    assign ram_addr = slot;

    // Unchanged slots are not rewritten
    assign ram_write_en = (state == sort_queue_pkg::ST_FILL) ||
                          ((state == sort_queue_pkg::ST_CMP_WRITE) && route.swap);

    assign ram_write_data = (state == sort_queue_pkg::ST_FILL) ? sort_queue_pkg::EMPTY_WORD
                                                               : route.write_word;

    // Queue is empty once the fill is running
    assign count_clear     = (state == sort_queue_pkg::ST_FILL);
    assign count_increment = (state == sort_queue_pkg::ST_FINISH);

    assign ready = (state == sort_queue_pkg::ST_IDLE);

endmodule

`default_nettype wire

// File: src/sort_queue_top.sv
`timescale 1ns/1ps
`default_nettype none

module sort_queue_top (
    input  logic                        clk,
    input  logic                        reset,
    // Insert request, one cycle, honoured while ready
    input  logic                        insert,
    input  sort_queue_pkg::queue_word_t insert_value,
    // Held steady while running
    input  sort_queue_pkg::slot_idx_t   capacity,
    // Look-up port, valid while ready
    input  sort_queue_pkg::slot_idx_t   read_addr,
    output sort_queue_pkg::queue_word_t read_data,
    output logic                        ready,
    output logic                        done,
    output logic                        rejected,
    output sort_queue_pkg::slot_idx_t   count
);

    sort_queue_pkg::slot_idx_t     ctrl_addr;
    sort_queue_pkg::slot_idx_t     ram_addr;
    logic                          ram_write_en;
    sort_queue_pkg::queue_word_t   ram_write_data;
    sort_queue_pkg::queue_word_t   ram_read_data;
    sort_queue_pkg::queue_word_t   carried;
    sort_queue_pkg::route_result_t route;
    sort_queue_pkg::count_status_t status;
    logic                          count_increment;
    logic                          count_clear;

    //////////////////////////////////////////////////
    // Shared RAM port
    //////////////////////////////////////////////////

    // Outside address only while the controller idles
    assign ram_addr = ready ? read_addr : ctrl_addr;

    queue_bram queue_bram_i (
        .clk        (clk),
        .addr       (ram_addr),
        .write_en   (ram_write_en),
        .write_data (ram_write_data),
        .read_data  (ram_read_data)
    );

    //////////////////////////////////////////////////
    // Datapath helpers
    //////////////////////////////////////////////////

    // Compare-and-swap on the RAM output
    value_router value_router_i (
        .carried (carried),
        .stored  (ram_read_data),
        .route   (route)
    );

    slot_counter slot_counter_i (
        .clk       (clk),
        .reset     (reset),
        .clear     (count_clear),
        .increment (count_increment),
        .capacity  (capacity),
        .status    (status)
    );

    //////////////////////////////////////////////////
    // Sequencing
    //////////////////////////////////////////////////

    insert_controller insert_controller_i (
        .clk             (clk),
        .reset           (reset),
        .insert          (insert),
        .insert_value    (insert_value),
        .route           (route),
        .status          (status),
        .ram_addr        (ctrl_addr),
        .ram_write_en    (ram_write_en),
        .ram_write_data  (ram_write_data),
        .carried         (carried),
        .count_increment (count_increment),
        .count_clear     (count_clear),
        .ready           (ready),
        .done            (done),
        .rejected        (rejected)
    );

    // Read-out straight from the RAM register
    assign read_data = ram_read_data;
    assign count     = status.count;

endmodule

`default_nettype wire

// File: sim/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    // 40 ns period
    localparam time HALF_PERIOD = 20ns;

    // Cycles with reset held high
    localparam int RESET_CYCLES = 3;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Released on a rising edge, like the other inputs
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

// File: sim/sort_queue_props.sv
`timescale 1ns/1ps
`default_nettype none

module sort_queue_props (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          ready,
    input  logic                          done,
    input  logic                          rejected,
    input  logic                          ram_write_en,
    input  logic                          count_increment,
    input  sort_queue_pkg::count_status_t status
);

    // One ending per command
    assert property (@(posedge clk) disable iff (reset) !(done && rejected))
        else $error("done and rejected were high in the same cycle");

    // Both endings are single cycle pulses
    assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else $error("done stayed high for more than one cycle");
    assert property (@(posedge clk) disable iff (reset) rejected |=> !rejected)
        else $error("rejected stayed high for more than one cycle");

    // RAM port belongs to the read-out path while idle
    assert property (@(posedge clk) disable iff (reset) ready |-> !ram_write_en)
        else $error("RAM write enabled while ready was high");

    // No growth past the limit, so the count stays within capacity
    assert property (@(posedge clk) disable iff (reset) status.full |-> !count_increment)
        else $error("entry count incremented while the queue was full");
    assert property (@(posedge clk) disable iff (reset)
        status.count <= sort_queue_pkg::slot_idx_t'(sort_queue_pkg::QUEUE_DEPTH))
        else $error("entry count went past the built depth");

endmodule

bind insert_controller sort_queue_props sort_queue_props_i (
    .clk             (clk),
    .reset           (reset),
    .ready           (ready),
    .done            (done),
    .rejected        (rejected),
    .ram_write_en    (ram_write_en),
    .count_increment (count_increment),
    .status          (status)
);

`default_nettype wire

// File: sim/sort_queue_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sort_queue_tb;

    localparam int DEPTH       = sort_queue_pkg::QUEUE_DEPTH;
    localparam int NUM_STEPS   = 23;
    // Reset, marker fill and the stray strobe before the first step
    localparam int FILL_CYCLES = 3 + DEPTH + 4;
    localparam int CYCLE_LIMIT = NUM_STEPS * (2 * DEPTH + 4) + FILL_CYCLES;

    typedef enum logic [1:0] {
        OP_CHECK,       // Read back every slot
        OP_INSERT,      // Insert the table value
        OP_INSERT_BUSY, // Same, plus a strobe during the walk
        OP_RANDOM       // Insert the next LCG value
    } step_op_t;

    typedef enum logic {
        EXPECT_DONE,
        EXPECT_REJECT
    } step_result_t;

    typedef struct packed {
        step_op_t                    op;
        sort_queue_pkg::queue_word_t value;
        sort_queue_pkg::slot_idx_t   capacity;
        step_result_t                outcome;
    } step_t;

    logic                        clk;
    logic                        reset;
    logic                        insert;
    sort_queue_pkg::queue_word_t insert_value;
    sort_queue_pkg::slot_idx_t   capacity;
    sort_queue_pkg::slot_idx_t   read_addr;
    sort_queue_pkg::queue_word_t read_data;
    logic                        ready;
    logic                        done;
    logic                        rejected;
    sort_queue_pkg::slot_idx_t   count;

    step_t                       steps [NUM_STEPS];
    // Reference queue, non-increasing, marker past the last entry
    sort_queue_pkg::queue_word_t model_words [DEPTH];
    int                          model_count;
    logic [31:0]                 lcg_state;
    int                          value_errors;
    int                          protocol_errors;
    int                          cycle_count;

    tb_clock_gen tb_clock_gen_i (
        .clk   (clk),
        .reset (reset)
    );

    sort_queue_top sort_queue_top_i (
        .clk          (clk),
        .reset        (reset),
        .insert       (insert),
        .insert_value (insert_value),
        .capacity     (capacity),
        .read_addr    (read_addr),
        .read_data    (read_data),
        .ready        (ready),
        .done         (done),
        .rejected     (rejected),
        .count        (count)
    );

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic step_t make_step(input step_op_t op, input logic [31:0] value,
                                        input logic [7:0] cap, input step_result_t outcome);
        step_t s;
        s.op       = op;
        s.value    = value;
        s.capacity = cap;
        s.outcome  = outcome;
        return s;
    endfunction

    task automatic expect_word(input logic [31:0] got, input logic [31:0] want,
                               input string what);
        assert (got == want) else begin
            value_errors++;
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        assert (cond) else begin
            protocol_errors++;
            $display("At %0t: %s", $time, what);
        end
    endtask

    // Insertion sort step, larger values toward slot 0
    task automatic add_to_model(input sort_queue_pkg::queue_word_t value);
        sort_queue_pkg::queue_word_t held;
        int j;
        j = model_count;
        model_words[j] = value;
        while (j > 0 && model_words[j] > model_words[j - 1]) begin
            held               = model_words[j - 1];
            model_words[j - 1] = model_words[j];
            model_words[j]     = held;
            j--;
        end
        model_count++;
    endtask

    // Pipelined read-out, one slot per cycle
    task automatic read_back_all();
        @(posedge clk);
        read_addr <= '0;
        for (int i = 0; i < DEPTH; i++) begin
            @(posedge clk);
            if (i < DEPTH - 1) begin
                read_addr <= sort_queue_pkg::slot_idx_t'(i + 1);
            end
            @(negedge clk);
            expect_true(ready, "ready dropped during the read-out");
            expect_word(read_data, model_words[i], $sformatf("slot %0d", i));
        end
        expect_word(32'(count), 32'(model_count), "count");
    endtask

    task automatic apply_insert(input sort_queue_pkg::queue_word_t value,
                                input step_result_t outcome, input logic busy);
        logic got_done;
        logic got_reject;
        @(posedge clk);
        insert       <= 1'b1;
        insert_value <= value;
        @(posedge clk);
        insert <= 1'b0;
        if (busy) begin
            // Stray strobe in the middle of the walk
            @(posedge clk);
            insert       <= 1'b1;
            insert_value <= 32'h1234_5678;
            @(negedge clk);
            expect_true(!ready, "ready was high during an insert walk");
            @(posedge clk);
            insert <= 1'b0;
        end
        if (outcome == EXPECT_REJECT) begin
            // Refusal comes on the cycle after the strobe
            @(negedge clk);
            expect_true(rejected && !done, "insert into a full queue was not rejected");
            repeat (3) begin
                @(negedge clk);
                expect_true(!done, "a rejected insert still gave done");
            end
        end else begin
            do begin
                @(negedge clk);
                got_done   = done;
                got_reject = rejected;
            end while (!got_done && !got_reject);
            expect_true(got_done, "insert was rejected although the queue had room");
            if (got_done) begin
                add_to_model(value);
            end
        end
        expect_word(32'(count), 32'(model_count), "count after insert");
    endtask

    //////////////////////////////////////////////////
    // Stimulus table
    //////////////////////////////////////////////////

    task automatic load_steps();
        steps[0]  = make_step(OP_CHECK,       32'h0000_0000, 8'd5,  EXPECT_DONE);
        steps[1]  = make_step(OP_INSERT,      32'h0000_0040, 8'd5,  EXPECT_DONE);
        steps[2]  = make_step(OP_INSERT,      32'h0000_1000, 8'd5,  EXPECT_DONE);
        steps[3]  = make_step(OP_INSERT,      32'h0000_0007, 8'd5,  EXPECT_DONE);
        steps[4]  = make_step(OP_INSERT,      32'h0000_1000, 8'd5,  EXPECT_DONE);
        steps[5]  = make_step(OP_CHECK,       32'h0000_0000, 8'd5,  EXPECT_DONE);
        steps[6]  = make_step(OP_INSERT_BUSY, 32'h0000_0040, 8'd5,  EXPECT_DONE);
        // Sixth entry with capacity 5
        steps[7]  = make_step(OP_INSERT,      32'h7FFF_0000, 8'd5,  EXPECT_REJECT);
        steps[8]  = make_step(OP_CHECK,       32'h0000_0000, 8'd5,  EXPECT_DONE);
        steps[9]  = make_step(OP_INSERT,      32'hFFFF_FFFE, 8'd16, EXPECT_DONE);
        steps[10] = make_step(OP_INSERT,      32'h0000_0000, 8'd16, EXPECT_DONE);
        steps[11] = make_step(OP_RANDOM,      32'h0000_0000, 8'd16, EXPECT_DONE);
        steps[12] = make_step(OP_RANDOM,      32'h0000_0000, 8'd16, EXPECT_DONE);
        steps[13] = make_step(OP_INSERT_BUSY, 32'h0000_1000, 8'd16, EXPECT_DONE);
        steps[14] = make_step(OP_RANDOM,      32'h0000_0000, 8'd16, EXPECT_DONE);
        steps[15] = make_step(OP_RANDOM,      32'h0000_0000, 8'd16, EXPECT_DONE);
        steps[16] = make_step(OP_RANDOM,      32'h0000_0000, 8'd16, EXPECT_DONE);
        steps[17] = make_step(OP_CHECK,       32'h0000_0000, 8'd16, EXPECT_DONE);
        steps[18] = make_step(OP_RANDOM,      32'h0000_0000, 8'd16, EXPECT_DONE);
        steps[19] = make_step(OP_RANDOM,      32'h0000_0000, 8'd16, EXPECT_DONE);
        steps[20] = make_step(OP_RANDOM,      32'h0000_0000, 8'd16, EXPECT_DONE);
        // Queue now holds the built depth
        steps[21] = make_step(OP_RANDOM,      32'h0000_0000, 8'd16, EXPECT_REJECT);
        steps[22] = make_step(OP_CHECK,       32'h0000_0000, 8'd16, EXPECT_DONE);
    endtask

    //////////////////////////////////////////////////
    // Run limit
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles without finishing the table", cycle_count);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        step_t                       entry;
        sort_queue_pkg::queue_word_t value;
        insert          = 1'b0;
        insert_value    = '0;
        capacity        = 8'd5;
        read_addr       = '0;
        model_count     = 0;
        lcg_state       = 32'hc531ca68;
        value_errors    = 0;
        protocol_errors = 0;
        cycle_count     = 0;
        for (int i = 0; i < DEPTH; i++) begin
            model_words[i] = sort_queue_pkg::EMPTY_WORD;
        end
        load_steps();

        // Strobe while the marker fill runs
        wait (reset == 1'b0);
        @(posedge clk);
        insert       <= 1'b1;
        insert_value <= 32'h0000_0055;
        @(negedge clk);
        expect_true(!ready, "ready was high during the marker fill");
        @(posedge clk);
        insert <= 1'b0;
        while (!ready) begin
            @(negedge clk);
        end
        expect_word(32'(count), 32'h0, "count after fill");

        for (int n = 0; n < NUM_STEPS; n++) begin
            entry = steps[n];
            @(posedge clk);
            capacity <= entry.capacity;
            case (entry.op)
                OP_CHECK: begin
                    read_back_all();
                end
                OP_INSERT: begin
                    apply_insert(entry.value, entry.outcome, 1'b0);
                end
                OP_INSERT_BUSY: begin
                    apply_insert(entry.value, entry.outcome, 1'b1);
                end
                default: begin
                    // Masked so the marker never comes up
                    lcg_state = lcg_next(lcg_state);
                    value     = lcg_state & 32'h7FFF_FFFF;
                    apply_insert(value, entry.outcome, 1'b0);
                end
            endcase
        end

        $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors + protocol_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
common/sort_queue_pkg.sv
src/value_router.sv
src/slot_counter.sv
src/queue_bram.sv
insert_ctrl/insert_controller.sv
src/sort_queue_top.sv
sim/tb_clock_gen.sv
sim/sort_queue_props.sv
sim/sort_queue_tb.sv

// File: Makefile
# Verilator build and run for the sorted queue

VERILATOR ?= verilator
TOP       ?= sort_queue_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass or fail comes from the log, not from the simulator's status
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
